// ==== flist.f ====
+incdir+include
source/rename_pkg.sv
source/rat.sv
source/rrat.sv
source/free_list.sv
source/rename_stage.sv
verif/rename_tb.sv

// ==== include/rename_params.svh ====
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// register file sizes for the rename stage
////////////////////////////////////////////////////////////////////////////

// architectural side
`define ARF_SIZE 32                // visible registers
`define ARF_IDX_W 5                // index into the map

// physical side
`define PRF_SIZE 64                // physical registers, spares included
`define PRF_IDX_W 6                // physical tag width

// the spare registers are the ones above the architectural range,
// so after reset the free list starts at ARF_SIZE
// keep PRF_SIZE a power of two and above ARF_SIZE

`endif

// ==== run_sim.sh ====
#!/bin/bash
# build and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f flist.f --top-module rename_tb \
	--Mdir "$OBJ" -o rename_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/rename_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^test failed$" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "^test passed$" "$LOG"; then
	echo "simulation gave no result"
	exit 1
fi
exit 0

// ==== source/free_list.sv ====
`timescale 1ns/1ns
`include "rename_params.svh"

module free_list (
	input  logic clock,
	input  logic reset,
	input  logic take1,                           // rat used free1
	input  logic take2,                           // rat used free2
	input  logic release_valid,                   // retire frees a tag
	input  logic [`PRF_IDX_W-1:0] release_phys,
	input  logic mispredict,                      // rebuild from committed
	input  rename_pkg::map_t committed_next,
	output logic avail1,                          // free1 is valid
	output logic avail2,                          // free2 is valid
	output logic [`PRF_IDX_W-1:0] free1,          // lowest free tag
	output logic [`PRF_IDX_W-1:0] free2           // next lowest free tag
);

	typedef struct packed {
		logic valid;
		logic [`PRF_IDX_W-1:0] idx;
	} pick_t;

	logic [`PRF_SIZE-1:0] free_q;                 // one bit per tag, 1 = free
	logic [`PRF_SIZE-1:0] free_d;
	logic [`PRF_SIZE-1:0] held;                   // tags in the committed map
	logic [`PRF_SIZE-1:0] first_mask;             // hides pick1 from pick2
	pick_t pick1;
	pick_t pick2;

	// priority picker, lowest set bit wins
	function automatic pick_t pick_lowest(input logic [`PRF_SIZE-1:0] vec);
		pick_t pick;
		pick = '0;
		for (int i = `PRF_SIZE - 1; i >= 0; i--) begin
			if (vec[i]) begin
				pick.valid = 1'b1;
				pick.idx = `PRF_IDX_W'(i);        // later hit is lower
			end
		end
		return pick;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// offers to the rat
	////////////////////////////////////////////////////////////////////////////

	assign pick1 = pick_lowest(free_q);
	assign first_mask = pick1.valid ? (`PRF_SIZE'(1) << pick1.idx) : '0;
	assign pick2 = pick_lowest(free_q & ~first_mask);

	assign avail1 = pick1.valid;
	assign avail2 = pick2.valid;
	assign free1 = pick1.idx;
	assign free2 = pick2.idx;

	////////////////////////////////////////////////////////////////////////////
	// bookkeeping
	////////////////////////////////////////////////////////////////////////////

	// everything the committed map points at stays busy after a flush
	always_comb begin
		held = '0;
		for (int i = 0; i < `ARF_SIZE; i++) begin
			held[committed_next[i]] = 1'b1;
		end
	end

	always_comb begin
		free_d = free_q;
		if (take1) begin
			free_d[free1] = 1'b0;                 // allocated this cycle
		end
		if (take2) begin
			free_d[free2] = 1'b0;
		end
		if (release_valid) begin
			free_d[release_phys] = 1'b1;          // usable after the edge
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// spares above the identity map start free
			free_q <= {{(`PRF_SIZE - `ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};
		end else if (mispredict) begin
			free_q <= ~held;                      // squashed tags come back
		end else begin
			free_q <= free_d;
		end
	end

endmodule

// ==== source/rat.sv ====
`timescale 1ns/1ns
`include "rename_params.svh"

module rat (
	input  logic clock,
	input  logic reset,
	input  rename_pkg::rename_req_t req1,         // older slot
	input  rename_pkg::rename_req_t req2,         // younger slot
	input  logic mispredict,                      // flush pulse
	input  logic avail1,                          // lowest free tag valid
	input  logic avail2,                          // second free tag valid
	input  logic [`PRF_IDX_W-1:0] free1,          // lowest free tag
	input  logic [`PRF_IDX_W-1:0] free2,          // second lowest free tag
	input  rename_pkg::map_t committed_next,      // retired map, post retire
	output rename_pkg::rename_resp_t resp1,
	output rename_pkg::rename_resp_t resp2,
	output logic take1,                           // first offered tag used
	output logic take2                            // second offered tag used
);
	import rename_pkg::*;

	map_t map_q;                                  // speculative map
	map_t map_d;
	logic want1;                                  // slot one needs a tag
	logic want2;
	logic rename1;                                // slot one gets a tag
	logic rename2;
	logic [`PRF_IDX_W-1:0] dest_phys1;            // tag written by slot one
	logic [`PRF_IDX_W-1:0] dest_phys2;
	logic [`PRF_IDX_W-1:0] opa_phys1;
	logic [`PRF_IDX_W-1:0] opb_phys1;
	logic [`PRF_IDX_W-1:0] opa_phys2;
	logic [`PRF_IDX_W-1:0] opb_phys2;

	// operand tag from the map at cycle start, with optional bypass
	function automatic logic [`PRF_IDX_W-1:0] operand_phys(
		input map_t map,
		input logic [`ARF_IDX_W-1:0] arch,
		input logic imm,
		input logic fwd,
		input logic [`ARF_IDX_W-1:0] fwd_arch,
		input logic [`PRF_IDX_W-1:0] fwd_phys
	);
		logic [`PRF_IDX_W-1:0] phys;
		if (imm) begin
			phys = '0;                            // immediates carry no tag
		end else if (fwd && (arch == fwd_arch)) begin
			phys = fwd_phys;                      // older slot in same group
		end else begin
			phys = map[arch];
		end
		return phys;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// slot allocation
	////////////////////////////////////////////////////////////////////////////

	assign want1 = req1.enable & req1.dest_valid;
	assign want2 = req2.enable & req2.dest_valid;

	// first offered tag always goes to the first slot that renames
	assign rename1 = want1 & avail1 & ~mispredict;
	assign rename2 = want2 & ~mispredict & (rename1 ? avail2 : avail1);

	assign take1 = rename1 | rename2;             // any rename eats free1
	assign take2 = rename1 & rename2;             // both eat free2 too

	////////////////////////////////////////////////////////////////////////////
	// next map
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		map_d = map_q;
		dest_phys1 = '0;
		dest_phys2 = '0;
		if (mispredict) begin
			map_d = committed_next;               // roll back to retired state
		end else begin
			case ({rename1, rename2})
				2'b00: begin
					map_d = map_q;                // nothing renames
				end
				2'b10: begin
					dest_phys1 = free1;
					map_d[req1.dest_arch] = free1;
				end
				2'b01: begin
					dest_phys2 = free1;           // slot two takes the first tag
					map_d[req2.dest_arch] = free1;
				end
				default: begin
					dest_phys1 = free1;
					dest_phys2 = free2;
					map_d[req1.dest_arch] = free1;
					map_d[req2.dest_arch] = free2; // younger write wins
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				map_q[i] <= `PRF_IDX_W'(i);       // identity map
			end
		end else begin
			map_q <= map_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// operand lookup and responses
	////////////////////////////////////////////////////////////////////////////

	assign opa_phys1 = operand_phys(map_q, req1.opa_arch, req1.opa_imm, 1'b0, '0, '0);
	assign opb_phys1 = operand_phys(map_q, req1.opb_arch, req1.opb_imm, 1'b0, '0, '0);
	assign opa_phys2 = operand_phys(map_q, req2.opa_arch, req2.opa_imm,
		rename1, req1.dest_arch, dest_phys1);     // bypass from slot one
	assign opb_phys2 = operand_phys(map_q, req2.opb_arch, req2.opb_imm,
		rename1, req1.dest_arch, dest_phys1);

	always_comb begin
		resp1 = '0;
		resp2 = '0;
		if (!mispredict) begin                    // flush cycle answers zero
			if (req1.enable) begin
				resp1.renamed = rename1;
				resp1.halt = want1 & ~rename1;    // no tag left for slot one
				resp1.dest_phys = dest_phys1;
				resp1.opa_phys = opa_phys1;       // looked up even on halt
				resp1.opb_phys = opb_phys1;
			end
			if (req2.enable) begin
				resp2.renamed = rename2;
				resp2.halt = want2 & ~rename2;
				resp2.dest_phys = dest_phys2;
				resp2.opa_phys = opa_phys2;
				resp2.opb_phys = opb_phys2;
			end
		end
	end

endmodule

// ==== source/rename_pkg.sv ====
`include "rename_params.svh"

package rename_pkg;

	////////////////////////////////////////////////////////////////////////////
	// rename request and response of one slot
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic enable;                      // slot holds an instruction
		logic dest_valid;                  // dest needs a new tag
		logic [`ARF_IDX_W-1:0] dest_arch;  // dest register
		logic [`ARF_IDX_W-1:0] opa_arch;   // operand a source
		logic opa_imm;                     // operand a is an immediate
		logic [`ARF_IDX_W-1:0] opb_arch;   // operand b source
		logic opb_imm;                     // operand b is an immediate
	} rename_req_t;

	typedef struct packed {
		logic renamed;                     // new mapping this cycle
		logic halt;                        // wanted a tag, none left
		logic [`PRF_IDX_W-1:0] dest_phys;  // new dest tag
		logic [`PRF_IDX_W-1:0] opa_phys;   // operand a tag
		logic [`PRF_IDX_W-1:0] opb_phys;   // operand b tag
	} rename_resp_t;

	////////////////////////////////////////////////////////////////////////////
	// retirement and whole maps
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic valid;                       // one instruction retires
		logic [`ARF_IDX_W-1:0] arch;       // its dest register
		logic [`PRF_IDX_W-1:0] phys;       // its dest tag
	} retire_t;

	// arch index selects the entry, entry holds the physical tag
	typedef logic [`ARF_SIZE-1:0][`PRF_IDX_W-1:0] map_t;

endpackage

// ==== source/rename_stage.sv ====
`timescale 1ns/1ns
`include "rename_params.svh"

module rename_stage (
	input  logic clock,
	input  logic reset,
	input  rename_pkg::rename_req_t req1,         // older slot
	input  rename_pkg::rename_req_t req2,         // younger slot
	input  logic mispredict,                      // one cycle flush
	input  rename_pkg::retire_t retire,
	output rename_pkg::rename_resp_t resp1,
	output rename_pkg::rename_resp_t resp2
);
	import rename_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////////////////////

	logic avail1;                                 // free list offers
	logic avail2;
	logic [`PRF_IDX_W-1:0] free1;
	logic [`PRF_IDX_W-1:0] free2;
	logic take1;                                  // rat consumption
	logic take2;
	map_t committed_next;                         // post retire map
	logic release_valid;                          // retire release
	logic [`PRF_IDX_W-1:0] release_phys;

	rat i_rat (
		.clock          (clock),
		.reset          (reset),
		.req1           (req1),
		.req2           (req2),
		.mispredict     (mispredict),
		.avail1         (avail1),
		.avail2         (avail2),
		.free1          (free1),
		.free2          (free2),
		.committed_next (committed_next),
		.resp1          (resp1),
		.resp2          (resp2),
		.take1          (take1),
		.take2          (take2)
	);

	rrat i_rrat (
		.clock          (clock),
		.reset          (reset),
		.retire         (retire),
		.committed      (),                       // only the next view is used here
		.committed_next (committed_next),
		.release_valid  (release_valid),
		.release_phys   (release_phys)
	);

	free_list i_free_list (
		.clock          (clock),
		.reset          (reset),
		.take1          (take1),
		.take2          (take2),
		.release_valid  (release_valid),
		.release_phys   (release_phys),
		.mispredict     (mispredict),
		.committed_next (committed_next),
		.avail1         (avail1),
		.avail2         (avail2),
		.free1          (free1),
		.free2          (free2)
	);

endmodule

// ==== source/rrat.sv ====
`timescale 1ns/1ns
`include "rename_params.svh"

module rrat (
	input  logic clock,
	input  logic reset,
	input  rename_pkg::retire_t retire,           // one retirement per cycle
	output rename_pkg::map_t committed,           // retired map
	output rename_pkg::map_t committed_next,      // map after this retire
	output logic release_valid,                   // old tag goes back
	output logic [`PRF_IDX_W-1:0] release_phys    // the replaced tag
);

	////////////////////////////////////////////////////////////////////////////
	// retirement view
	////////////////////////////////////////////////////////////////////////////

	// the tag that was committed for this register is now dead
	assign release_valid = retire.valid;
	assign release_phys = committed[retire.arch];

	// rat and free list copy this on a flush, so a same cycle retire
	// is already folded in
	always_comb begin
		committed_next = committed;
		if (retire.valid) begin
			committed_next[retire.arch] = retire.phys;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// committed map
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				committed[i] <= `PRF_IDX_W'(i);   // identity at start
			end
		end else begin
			committed <= committed_next;          // write the retired tag
		end
	end

endmodule

// ==== verif/rename_stim.txt ====
# test req1 req2 mispredict retire exp_resp1 exp_resp2, all hex, one line per cycle
# req {en,dv,dest,opa,opa_imm,opb,opb_imm}, resp {renamed,halt,dest,opa,opb}, retire {v,arch,phys}
1 4028E 40F87 0 000 00147 007C0
1 404C0 24200 0 000 00000 00000
1 40802 00000 0 000 00401 00000
2 63188 6518C 0 000 A00C4 A1806
2 4018A 6738A 0 000 00821 A21E1
2 69084 69492 0 000 A3042 A48E3
2 4048E 40281 0 000 00922 00840
3 6A000 6B000 0 000 A5000 A6000
3 6A000 6B000 0 000 A7000 A8000
3 6A000 6B000 0 000 A9000 AA000
3 6A000 6B000 0 000 AB000 AC000
3 6A000 6B000 0 000 AD000 AE000
3 6A000 6B000 0 000 AF000 B0000
3 6A000 6B000 0 000 B1000 B2000
3 6A000 6B000 0 000 B3000 B4000
3 6A000 6B000 0 000 B5000 B6000
3 6A000 6B000 0 000 B7000 B8000
3 6A000 6B000 0 000 B9000 BA000
3 6A000 6B000 0 000 BB000 BC000
3 6A000 6B000 0 000 BD000 BE000
3 6A000 6B000 0 000 BF000 40000
3 6C516 40192 0 000 40FFE 00824
4 00000 00000 0 8E0 00000 00000
4 6D69A 6E000 0 961 8334D 40000
4 40680 6F680 0 000 000C0 850C0
5 63188 6518C 1 9E2 00000 00000
5 4018A 40392 0 000 00821 00889
5 74000 75000 0 000 83000 85000
5 76000 77000 0 000 87000 A3000
5 40A2A 40B2E 0 000 000C5 001E3

// ==== verif/rename_tb.sv ====
`timescale 1ns/1ns

module rename_tb;
	import rename_pkg::*;

	localparam int CLK_PERIOD = 10;               // ns
	localparam string STIM_FILE = "verif/rename_stim.txt";

	logic clock;
	logic reset;
	rename_req_t req1;
	rename_req_t req2;
	logic mispredict;
	retire_t retire;
	rename_resp_t resp1;
	rename_resp_t resp2;

	// one entry per vector line
	int test_q[$];
	rename_req_t req1_q[$];
	rename_req_t req2_q[$];
	logic misp_q[$];
	retire_t retire_q[$];
	rename_resp_t exp1_q[$];
	rename_resp_t exp2_q[$];

	int vec_count;
	bit loaded;                                   // vectors in memory
	int tests_ok;
	int tests_bad;
	int errors;                                   // all checks that failed
	int test_errors;                              // checks failed in this test

	rename_stage i_dut (
		.clock      (clock),
		.reset      (reset),
		.req1       (req1),
		.req2       (req2),
		.mispredict (mispredict),
		.retire     (retire),
		.resp1      (resp1),
		.resp2      (resp2)
	);

	////////////////////////////////////////////////////////////////////////////
	// clock, vectors and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic load_vectors();
		int fd;
		int code;
		string line;
		logic [31:0] f_test;
		logic [31:0] f_req1;
		logic [31:0] f_req2;
		logic [31:0] f_misp;
		logic [31:0] f_ret;
		logic [31:0] f_exp1;
		logic [31:0] f_exp2;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open %s", STIM_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#") begin
					continue;                     // comment or blank
				end
				code = $sscanf(line, "%h %h %h %h %h %h %h", f_test, f_req1, f_req2,
					f_misp, f_ret, f_exp1, f_exp2);
				if (code == 7) begin
					test_q.push_back(int'(f_test));
					req1_q.push_back(rename_req_t'(f_req1[18:0]));
					req2_q.push_back(rename_req_t'(f_req2[18:0]));
					misp_q.push_back(f_misp[0]);
					retire_q.push_back(retire_t'(f_ret[11:0]));
					exp1_q.push_back(rename_resp_t'(f_exp1[19:0]));
					exp2_q.push_back(rename_resp_t'(f_exp2[19:0]));
				end
			end
			$fclose(fd);
		end
	endtask

	// limit is the vector count plus some slack for reset
	initial begin
		wait (loaded);
		#((vec_count + 20) * CLK_PERIOD);
		$display("timeout, run did not end within %0d cycles", vec_count + 20);
		$display("test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks and per test reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic check_resp(input string name, input rename_resp_t actual,
		input rename_resp_t expected);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			test_errors++;
			errors++;
		end
	endtask

	task automatic report_test(input int num);
		if (test_errors == 0) begin
			$display("test %0d passed", num);
			tests_ok++;
		end else begin
			$display("test %0d failed with %0d errors", num, test_errors);
			tests_bad++;
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int cur_test;
		reset = 1'b1;                             // all inputs idle first
		req1 = '0;
		req2 = '0;
		mispredict = 1'b0;
		retire = '0;
		tests_ok = 0;
		tests_bad = 0;
		errors = 0;
		test_errors = 0;
		loaded = 1'b0;
		load_vectors();
		vec_count = test_q.size();
		loaded = 1'b1;
		if (vec_count == 0) begin
			$display("no vectors found in %s", STIM_FILE);
			errors++;
		end
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		cur_test = (vec_count > 0) ? test_q[0] : 0;
		for (int i = 0; i < vec_count; i++) begin
			@(posedge clock);
			if (test_q[i] != cur_test) begin
				report_test(cur_test);            // previous test is done
				cur_test = test_q[i];
			end
			req1 <= req1_q[i];
			req2 <= req2_q[i];
			mispredict <= misp_q[i];
			retire <= retire_q[i];
			#(CLK_PERIOD - 1);                    // just before next edge
			check_resp("resp1", resp1, exp1_q[i]);
			check_resp("resp2", resp2, exp2_q[i]);
		end
		@(posedge clock);
		req1 <= '0;
		req2 <= '0;
		mispredict <= 1'b0;
		retire <= '0;
		if (vec_count > 0) begin
			report_test(cur_test);
		end
		$display("%0d tests ok, %0d tests with errors, %0d bad checks",
			tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
